// ==== rotator_settings.svh ====
`ifndef ROTATOR_SETTINGS_SVH
`define ROTATOR_SETTINGS_SVH

////////////////////////////////////////
// Sprite geometry.
////////////////////////////////////////

`define ROT_IMAGE_SIZE  16
`define ROT_COOR_WIDTH  4
`define ROT_COLOR_WIDTH 4

////////////////////////////////////////
// Angle and trig precision.
////////////////////////////////////////

// Signed, 512 steps per turn, positive is counter-clockwise.
`define ROT_ANG_WIDTH   9
`define ROT_TRIG_FRAC   8

`endif

// ==== rotator_pkg.sv ====
`include "rotator_settings.svh"

package rotator_pkg;

    // Pixel coordinate inside the sprite.
    typedef logic [`ROT_COOR_WIDTH-1:0] coor_t;

    // Colour index, zero is transparent.
    typedef logic [`ROT_COLOR_WIDTH-1:0] color_t;

    typedef logic signed [`ROT_ANG_WIDTH-1:0] angle_t;

    // Sign, one integer bit and the fraction.
    typedef logic signed [`ROT_TRIG_FRAC+1:0] trig_t;

    typedef enum logic [1:0] {
        SCAN_IDLE = 2'd0,
        SCAN_RUN  = 2'd1,
        SCAN_HOLD = 2'd2
    } scan_state_e;

endpackage

// ==== coord_rotate_if.sv ====
interface coord_rotate_if;

    // Request side, one coordinate per cycle.
    logic                 req_valid;
    rotator_pkg::coor_t   req_h;
    rotator_pkg::coor_t   req_v;
    rotator_pkg::angle_t  req_angle;

    // Result side, three cycles later.
    logic                 rsp_valid;
    rotator_pkg::coor_t   rsp_src_h;
    rotator_pkg::coor_t   rsp_src_v;
    logic                 rsp_out_of_range;
    rotator_pkg::coor_t   rsp_dst_h;
    rotator_pkg::coor_t   rsp_dst_v;
    logic                 rsp_last;

    modport req (
        output req_valid, req_h, req_v, req_angle,
        input  rsp_valid, rsp_src_h, rsp_src_v, rsp_out_of_range,
        input  rsp_dst_h, rsp_dst_v, rsp_last
    );

    modport rsp (
        input  req_valid, req_h, req_v, req_angle,
        output rsp_valid, rsp_src_h, rsp_src_v, rsp_out_of_range,
        output rsp_dst_h, rsp_dst_v, rsp_last
    );

endinterface

// ==== sin_cos_table.sv ====
`include "rotator_settings.svh"

module sin_cos_table (
    input  rotator_pkg::angle_t i_angle,
    output rotator_pkg::trig_t  o_sin,
    output rotator_pkg::trig_t  o_cos
);

    localparam int IDX_W = `ROT_ANG_WIDTH - 2;
    localparam int QUART = 1 << IDX_W;
    localparam real PI = 3.14159265358979323846;

    typedef rotator_pkg::trig_t qtab_t [0:QUART];

    function automatic qtab_t build_qtab();
        qtab_t tab;
        real   phase;
        for (int i = 0; i <= QUART; i++) begin
            phase  = 2.0 * PI * i / (4 * QUART);
            tab[i] = rotator_pkg::trig_t'(int'($sin(phase) * (1 << `ROT_TRIG_FRAC)));
        end
        return tab;
    endfunction

    // First quadrant including the quarter-turn point.
    localparam qtab_t QTAB = build_qtab();

    logic [1:0]         quad;
    logic [IDX_W-1:0]   idx;
    logic [IDX_W:0]     rev_idx;
    rotator_pkg::trig_t t_fwd;
    rotator_pkg::trig_t t_rev;

    assign quad    = i_angle[`ROT_ANG_WIDTH-1 -: 2];
    assign idx     = i_angle[IDX_W-1:0];
    assign rev_idx = (IDX_W+1)'(QUART) - {1'b0, idx};
    assign t_fwd   = QTAB[idx];
    assign t_rev   = QTAB[rev_idx];

    // Cosine is sine a quarter turn ahead.
    always_comb begin
        unique case (quad)
            2'd0: begin
                o_sin = t_fwd;
                o_cos = t_rev;
            end
            2'd1: begin
                o_sin = t_rev;
                o_cos = -t_fwd;
            end
            2'd2: begin
                o_sin = -t_fwd;
                o_cos = -t_rev;
            end
            default: begin
                o_sin = -t_rev;
                o_cos = t_fwd;
            end
        endcase
    end

endmodule

// ==== rotate_coor.sv ====
`include "rotator_settings.svh"

module rotate_coor (
    input  logic              i_clk,
    input  logic              i_rst_n,
    coord_rotate_if.rsp       rot
);

    localparam int COOR_W = `ROT_COOR_WIDTH;
    localparam int OFF_W  = COOR_W + 2;
    localparam int TRIG_W = $bits(rotator_pkg::trig_t);
    localparam int PROD_W = OFF_W + TRIG_W;
    localparam int SUM_W  = PROD_W + 2;

    localparam rotator_pkg::coor_t LAST = COOR_W'(`ROT_IMAGE_SIZE - 1);
    localparam logic signed [OFF_W-1:0] CENTRE = OFF_W'(`ROT_IMAGE_SIZE - 1);
    // Centre shift plus half a pixel for rounding.
    localparam logic signed [SUM_W-1:0] ROUND_OFF = SUM_W'(`ROT_IMAGE_SIZE << `ROT_TRIG_FRAC);

    rotator_pkg::trig_t sin_c;
    rotator_pkg::trig_t cos_c;

    sin_cos_table u_sin_cos_table (
        .i_angle (rot.req_angle),
        .o_sin   (sin_c),
        .o_cos   (cos_c)
    );

    logic signed [OFF_W-1:0] dx_c;
    logic signed [OFF_W-1:0] dy_c;

    // Doubled offsets from the sprite centre.
    assign dx_c = $signed({1'b0, rot.req_h, 1'b0}) - CENTRE;
    assign dy_c = $signed({1'b0, rot.req_v, 1'b0}) - CENTRE;

    ////////////////////////////////////////
    // Pipeline registers.
    ////////////////////////////////////////

    logic                      s1_valid;
    logic signed [OFF_W-1:0]   s1_dx;
    logic signed [OFF_W-1:0]   s1_dy;
    rotator_pkg::trig_t        s1_sin;
    rotator_pkg::trig_t        s1_cos;
    rotator_pkg::coor_t        s1_dst_h;
    rotator_pkg::coor_t        s1_dst_v;
    logic                      s1_last;

    logic                      s2_valid;
    logic signed [PROD_W-1:0]  s2_cx;
    logic signed [PROD_W-1:0]  s2_sy;
    logic signed [PROD_W-1:0]  s2_sx;
    logic signed [PROD_W-1:0]  s2_cy;
    rotator_pkg::coor_t        s2_dst_h;
    rotator_pkg::coor_t        s2_dst_v;
    logic                      s2_last;

    logic signed [SUM_W-1:0]   sum_x;
    logic signed [SUM_W-1:0]   sum_y;
    logic signed [SUM_W-1:0]   src_x;
    logic signed [SUM_W-1:0]   src_y;
    logic                      oor_c;

    assign sum_x = s2_cx + s2_sy + ROUND_OFF;
    assign sum_y = s2_cy - s2_sx + ROUND_OFF;
    // Floor divide back to single pixel units.
    assign src_x = sum_x >>> (`ROT_TRIG_FRAC + 1);
    assign src_y = sum_y >>> (`ROT_TRIG_FRAC + 1);
    assign oor_c = (src_x < 0) || (src_x > `ROT_IMAGE_SIZE - 1) ||
                   (src_y < 0) || (src_y > `ROT_IMAGE_SIZE - 1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            rot.rsp_valid <= 1'b0;
        end else begin
            s1_valid      <= rot.req_valid;
            s2_valid      <= s1_valid;
            rot.rsp_valid <= s2_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_dx    <= dx_c;
        s1_dy    <= dy_c;
        s1_sin   <= sin_c;
        s1_cos   <= cos_c;
        s1_dst_h <= rot.req_h;
        s1_dst_v <= rot.req_v;
        s1_last  <= (rot.req_h == LAST) && (rot.req_v == LAST);

        s2_cx    <= s1_cos * s1_dx;
        s2_sy    <= s1_sin * s1_dy;
        s2_sx    <= s1_sin * s1_dx;
        s2_cy    <= s1_cos * s1_dy;
        s2_dst_h <= s1_dst_h;
        s2_dst_v <= s1_dst_v;
        s2_last  <= s1_last;

        rot.rsp_src_h        <= src_x[COOR_W-1:0];
        rot.rsp_src_v        <= src_y[COOR_W-1:0];
        rot.rsp_out_of_range <= oor_c;
        rot.rsp_dst_h        <= s2_dst_h;
        rot.rsp_dst_v        <= s2_dst_v;
        rot.rsp_last         <= s2_last;
    end

    latency_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        rot.rsp_valid == $past(rot.req_valid, 3));

endmodule

// ==== sprite_store.sv ====
`include "rotator_settings.svh"

module sprite_store (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_wr_en,
    input  rotator_pkg::coor_t  i_wr_h,
    input  rotator_pkg::coor_t  i_wr_v,
    input  rotator_pkg::color_t i_wr_data,
    input  rotator_pkg::coor_t  i_rd_h,
    input  rotator_pkg::coor_t  i_rd_v,
    output rotator_pkg::color_t o_rd_data
);

    localparam int DEPTH = `ROT_IMAGE_SIZE * `ROT_IMAGE_SIZE;

    // Row-major, row index in the upper address bits.
    rotator_pkg::color_t mem [0:DEPTH-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr_en) begin
            mem[{i_wr_v, i_wr_h}] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[{i_rd_v, i_rd_h}];

endmodule

// ==== image_rotator.sv ====
`include "rotator_settings.svh"

module image_rotator (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  rotator_pkg::angle_t i_angle,
    coord_rotate_if.req         rot,
    output rotator_pkg::coor_t  o_rd_h,
    output rotator_pkg::coor_t  o_rd_v,
    input  rotator_pkg::color_t i_rd_data,
    output rotator_pkg::color_t o_pixel,
    output logic                o_opacity,
    output rotator_pkg::coor_t  o_dst_h,
    output rotator_pkg::coor_t  o_dst_v,
    output logic                o_valid,
    output logic                o_frame_done
);

    localparam rotator_pkg::coor_t LAST = `ROT_COOR_WIDTH'(`ROT_IMAGE_SIZE - 1);

    rotator_pkg::scan_state_e state;
    rotator_pkg::coor_t       scan_h;
    rotator_pkg::coor_t       scan_v;
    rotator_pkg::angle_t      frame_angle;
    logic                     scan_last;
    logic                     hit;

    assign scan_last = (scan_h == LAST) && (scan_v == LAST);

    ////////////////////////////////////////
    // Raster scanner.
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= rotator_pkg::SCAN_IDLE;
            scan_h <= '0;
            scan_v <= '0;
        end else begin
            unique case (state)
                rotator_pkg::SCAN_IDLE: begin
                    if (i_start) begin
                        state  <= rotator_pkg::SCAN_RUN;
                        scan_h <= '0;
                        scan_v <= '0;
                    end
                end
                rotator_pkg::SCAN_RUN: begin
                    if (!i_start) begin
                        state <= rotator_pkg::SCAN_IDLE;
                    end else if (scan_last) begin
                        state <= rotator_pkg::SCAN_HOLD;
                    end else begin
                        scan_h <= scan_h + 1'b1;
                        if (scan_h == LAST) begin
                            scan_v <= scan_v + 1'b1;
                        end
                    end
                end
                // Wait for start to drop.
                rotator_pkg::SCAN_HOLD: begin
                    if (!i_start) begin
                        state <= rotator_pkg::SCAN_IDLE;
                    end
                end
                default: state <= rotator_pkg::SCAN_IDLE;
            endcase
        end
    end

    // Angle is frozen for the whole frame.
    always_ff @(posedge i_clk) begin
        if (state == rotator_pkg::SCAN_IDLE && i_start) begin
            frame_angle <= i_angle;
        end
    end

    assign rot.req_valid = (state == rotator_pkg::SCAN_RUN);
    assign rot.req_h     = scan_h;
    assign rot.req_v     = scan_v;
    assign rot.req_angle = frame_angle;

    ////////////////////////////////////////
    // Pixel lookup.
    ////////////////////////////////////////

    assign o_rd_h = rot.rsp_src_h;
    assign o_rd_v = rot.rsp_src_v;

    assign hit          = rot.rsp_valid && !rot.rsp_out_of_range;
    assign o_pixel      = hit ? i_rd_data : '0;
    assign o_opacity    = hit && (i_rd_data != '0);
    assign o_dst_h      = rot.rsp_dst_h;
    assign o_dst_v      = rot.rsp_dst_v;
    assign o_valid      = rot.rsp_valid;
    assign o_frame_done = rot.rsp_valid && rot.rsp_last;

    // Raster order advances by exactly one pixel per running cycle.
    scan_step_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == rotator_pkg::SCAN_RUN && i_start && !scan_last) |=>
        (state == rotator_pkg::SCAN_RUN &&
         {scan_v, scan_h} == $past({scan_v, scan_h}) + 1'b1));

endmodule

// ==== rotator_top.sv ====
module rotator_top (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  rotator_pkg::angle_t i_angle,
    input  logic                i_wr_en,
    input  rotator_pkg::coor_t  i_wr_h,
    input  rotator_pkg::coor_t  i_wr_v,
    input  rotator_pkg::color_t i_wr_data,
    output rotator_pkg::color_t o_pixel,
    output logic                o_opacity,
    output rotator_pkg::coor_t  o_dst_h,
    output rotator_pkg::coor_t  o_dst_v,
    output logic                o_valid,
    output logic                o_frame_done
);

    rotator_pkg::coor_t  rd_h;
    rotator_pkg::coor_t  rd_v;
    rotator_pkg::color_t rd_data;

    coord_rotate_if rot_if ();

    sprite_store u_sprite_store (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (i_wr_en),
        .i_wr_h    (i_wr_h),
        .i_wr_v    (i_wr_v),
        .i_wr_data (i_wr_data),
        .i_rd_h    (rd_h),
        .i_rd_v    (rd_v),
        .o_rd_data (rd_data)
    );

    image_rotator u_image_rotator (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_angle      (i_angle),
        .rot          (rot_if),
        .o_rd_h       (rd_h),
        .o_rd_v       (rd_v),
        .i_rd_data    (rd_data),
        .o_pixel      (o_pixel),
        .o_opacity    (o_opacity),
        .o_dst_h      (o_dst_h),
        .o_dst_v      (o_dst_v),
        .o_valid      (o_valid),
        .o_frame_done (o_frame_done)
    );

    rotate_coor u_rotate_coor (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .rot     (rot_if)
    );

endmodule

// ==== tb_rotator_tests.svh ====
`ifndef TB_ROTATOR_TESTS_SVH
`define TB_ROTATOR_TESTS_SVH

////////////////////////////////////////
// Reference model.
////////////////////////////////////////

// Sine or cosine times 256, nearest integer.
function automatic int trig_fixed(input int ang, input bit want_cos);
    real phase;
    real value;
    phase = 2.0 * PI * ang / 512.0;
    value = want_cos ? $cos(phase) : $sin(phase);
    return $rtoi($floor(value * 256.0 + 0.5));
endfunction

// Fills the expected frame for one angle.
task automatic compute_expected(input int ang, input bit exact);
    int s;
    int c;
    int dx;
    int dy;
    int sh;
    int sv;
    s = trig_fixed(ang, 1'b0);
    c = trig_fixed(ang, 1'b1);
    for (int v = 0; v < 16; v++) begin
        for (int h = 0; h < 16; h++) begin
            if (exact) begin
                // Quarter turns map pixel centres onto pixel centres.
                case (ang)
                    128: begin
                        sh = v;
                        sv = 15 - h;
                    end
                    -256: begin
                        sh = 15 - h;
                        sv = 15 - v;
                    end
                    -128: begin
                        sh = 15 - v;
                        sv = h;
                    end
                    default: begin
                        sh = h;
                        sv = v;
                    end
                endcase
            end else begin
                dx = 2 * h - 15;
                dy = 2 * v - 15;
                sh = (c * dx + s * dy + 15 * 256 + 256) >>> 9;
                sv = (c * dy - s * dx + 15 * 256 + 256) >>> 9;
            end
            if (sh < 0 || sh > 15 || sv < 0 || sv > 15) begin
                exp_pix[v * 16 + h] = '0;
                exp_op[v * 16 + h]  = 1'b0;
            end else begin
                exp_pix[v * 16 + h] = sprite_ref[sv * 16 + sh];
                exp_op[v * 16 + h]  = (sprite_ref[sv * 16 + sh] != '0);
            end
        end
    end
endtask

////////////////////////////////////////
// Stimulus helpers.
////////////////////////////////////////

// About one pixel in four is transparent.
function automatic rotator_pkg::color_t random_color();
    rng = xorshift32(rng);
    if (rng[9:8] == 2'd0) begin
        return '0;
    end
    return (rng[3:0] == 4'd0) ? 4'd1 : rng[3:0];
endfunction

task automatic write_pixel(input int h, input int v, input rotator_pkg::color_t data);
    @(posedge clk);
    #1;
    wr_en   = 1'b1;
    wr_h    = h[3:0];
    wr_v    = v[3:0];
    wr_data = data;
    sprite_ref[v * 16 + h] = data;
endtask

task automatic end_writes();
    @(posedge clk);
    #1;
    wr_en = 1'b0;
endtask

task automatic load_sprite();
    for (int v = 0; v < 16; v++) begin
        for (int h = 0; h < 16; h++) begin
            write_pixel(h, v, random_color());
        end
    end
    end_writes();
endtask

task automatic check_value(input string what, input int got, input int expected);
    if (got != expected) begin
        errors++;
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", what, got, expected);
    end
endtask

task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
        $display("test %-24s ok", name);
    end else begin
        $display("test %-24s %0d errors", name, errors - err_before);
    end
endtask

////////////////////////////////////////
// Test sequences.
////////////////////////////////////////

task automatic run_frame(input int ang, input bit exact, input string name);
    int err_before;
    int wait_cycles;
    err_before = errors;
    compute_expected(ang, exact);
    @(posedge clk);
    #1;
    angle = ang[8:0];
    start = 1'b1;
    wait_cycles = 0;
    @(negedge clk);
    while (!frame_done && wait_cycles < FRAME_LIMIT) begin
        @(negedge clk);
        wait_cycles++;
    end
    if (!frame_done) begin
        errors++;
        $display("frame at angle %0d never signalled frame done", ang);
    end
    // Start stays high, nothing more may come out.
    repeat (4) @(posedge clk);
    #1;
    start = 1'b0;
    repeat (3) @(negedge clk);
    check_value("valid pixel count", pix_idx, 256);
    check_value("o_frame_done count", done_cnt, 1);
    finish_test(name, err_before);
endtask

task automatic abort_frame();
    int err_before;
    int wait_cycles;
    err_before = errors;
    compute_expected(0, 1'b1);
    abort_mode = 1'b1;
    @(posedge clk);
    #1;
    angle = '0;
    start = 1'b1;
    wait_cycles = 0;
    @(negedge clk);
    while (pix_idx < 9'd64 && wait_cycles < FRAME_LIMIT) begin
        @(negedge clk);
        wait_cycles++;
    end
    if (pix_idx < 9'd64) begin
        errors++;
        $display("aborted frame never reached its 64th pixel");
    end
    @(posedge clk);
    #1;
    start = 1'b0;
    repeat (8) @(negedge clk);
    check_value("o_frame_done count", done_cnt, 0);
    abort_mode = 1'b0;
    finish_test("abort mid-frame", err_before);
endtask

// Inverting every colour also turns 0xf into transparent.
task automatic rewrite_rows();
    for (int v = 0; v < 2; v++) begin
        for (int h = 0; h < 16; h++) begin
            write_pixel(h, v, ~sprite_ref[v * 16 + h]);
        end
    end
    end_writes();
endtask

task automatic run_all_tests();
    int err_before;
    int ang;
    err_before = errors;
    check_value("o_valid", valid, 0);
    check_value("o_frame_done", frame_done, 0);
    check_value("o_opacity", opacity, 0);
    finish_test("reset state", err_before);
    load_sprite();
    run_frame(0, 1'b1, "angle 0");
    run_frame(128, 1'b1, "angle 128");
    run_frame(-256, 1'b1, "angle -256");
    run_frame(-128, 1'b1, "angle -128");
    repeat (2) begin
        rng = xorshift32(rng);
        ang = int'($signed(rng[8:0]));
        run_frame(ang, 1'b0, $sformatf("random angle %0d", ang));
    end
    abort_frame();
    run_frame(0, 1'b1, "restart after abort");
    rewrite_rows();
    run_frame(0, 1'b1, "rewritten sprite");
endtask

`endif

// ==== tb_rotator_top.sv ====
`include "rotator_settings.svh"

module tb_rotator_top;

    localparam real PI = 3.14159265358979323846;
    localparam int FRAME_LIMIT = 300;
    // Eight frames with margin, plus the two sprite loads.
    localparam int WATCHDOG_TIME = (8 * (256 + 20) + 2 * 256) * 4;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    rotator_pkg::angle_t angle;
    logic                wr_en;
    rotator_pkg::coor_t  wr_h;
    rotator_pkg::coor_t  wr_v;
    rotator_pkg::color_t wr_data;
    rotator_pkg::color_t pixel;
    logic                opacity;
    rotator_pkg::coor_t  dst_h;
    rotator_pkg::coor_t  dst_v;
    logic                valid;
    logic                frame_done;

    // Sprite copy and the frame the DUT should produce.
    rotator_pkg::color_t sprite_ref [0:255];
    rotator_pkg::color_t exp_pix [0:255];
    logic                exp_op [0:255];
    rotator_pkg::color_t exp_pixel;
    logic                exp_opacity;

    logic        start_q;
    logic        start_rise;
    logic [8:0]  pix_idx;
    int          done_cnt;
    int          tail_cnt;
    logic        abort_mode;
    logic [31:0] rng;
    int          errors;
    int          tests_run;

    always #2 clk = ~clk;

    rotator_top rotator_top_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .i_angle      (angle),
        .i_wr_en      (wr_en),
        .i_wr_h       (wr_h),
        .i_wr_v       (wr_v),
        .i_wr_data    (wr_data),
        .o_pixel      (pixel),
        .o_opacity    (opacity),
        .o_dst_h      (dst_h),
        .o_dst_v      (dst_v),
        .o_valid      (valid),
        .o_frame_done (frame_done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    `include "tb_rotator_tests.svh"

    assign start_rise  = start && !start_q;
    assign exp_pixel   = exp_pix[pix_idx[7:0]];
    assign exp_opacity = exp_op[pix_idx[7:0]];

    // Position in the output stream since the last start.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q  <= 1'b0;
            pix_idx  <= '0;
            done_cnt <= 0;
            tail_cnt <= 0;
        end else begin
            start_q <= start;
            if (start_rise) begin
                pix_idx  <= '0;
                done_cnt <= 0;
                tail_cnt <= 0;
            end else begin
                if (valid) begin
                    pix_idx <= pix_idx + 1'b1;
                end
                if (frame_done) begin
                    done_cnt <= done_cnt + 1;
                end
                if (valid && !start_q) begin
                    tail_cnt <= tail_cnt + 1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Output stream checks.
    ////////////////////////////////////////

    pixel_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> pixel == exp_pixel)
        else begin
            errors++;
            $display("CHECK FAILED o_pixel at (%0d,%0d): got 0x%h expected 0x%h",
                     $sampled(dst_h), $sampled(dst_v), $sampled(pixel), $sampled(exp_pixel));
        end

    opacity_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> opacity == exp_opacity)
        else begin
            errors++;
            $display("CHECK FAILED o_opacity at (%0d,%0d): got 0x%h expected 0x%h",
                     $sampled(dst_h), $sampled(dst_v), $sampled(opacity),
                     $sampled(exp_opacity));
        end

    dst_h_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> dst_h == pix_idx[3:0])
        else begin
            errors++;
            $display("CHECK FAILED o_dst_h: got 0x%h expected 0x%h",
                     $sampled(dst_h), $sampled(pix_idx[3:0]));
        end

    dst_v_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> dst_v == pix_idx[7:4])
        else begin
            errors++;
            $display("CHECK FAILED o_dst_v: got 0x%h expected 0x%h",
                     $sampled(dst_v), $sampled(pix_idx[7:4]));
        end

    extra_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> pix_idx < 9'd256)
        else begin
            errors++;
            $display("a valid pixel came out after the frame was complete");
        end

    done_a: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> valid && pix_idx == 9'd255 && done_cnt == 0 && !abort_mode)
        else begin
            errors++;
            $display("frame done pulsed at pixel %0d, not once on the last pixel",
                     $sampled(pix_idx));
        end

    first_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(valid) |-> $past(start_rise, 4))
        else begin
            errors++;
            $display("first valid pixel did not come 4 cycles after start");
        end

    start_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start_rise, 4) |-> valid)
        else begin
            errors++;
            $display("no valid pixel 4 cycles after start");
        end

    no_gap_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(valid) |-> $past(frame_done) || abort_mode)
        else begin
            errors++;
            $display("valid stream broke off before the frame ended");
        end

    tail_a: assert property (@(posedge clk) disable iff (!rst_n)
        (valid && !start_q) |-> tail_cnt < 3)
        else begin
            errors++;
            $display("more than 3 pixels came out after start dropped");
        end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units", WATCHDOG_TIME);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        angle      = '0;
        wr_en      = 1'b0;
        wr_h       = '0;
        wr_v       = '0;
        wr_data    = '0;
        abort_mode = 1'b0;
        rng        = 32'd56625;
        errors     = 0;
        tests_run  = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        run_all_tests();
        $display("tests run: %0d, checks failed: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== rotator_top.f ====
+incdir+.
rotator_pkg.sv
coord_rotate_if.sv
sin_cos_table.sv
rotate_coor.sv
sprite_store.sv
image_rotator.sv
rotator_top.sv
tb_rotator_top.sv

// ==== Makefile ====
TOP := tb_rotator_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f rotator_top.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f rotator_top.f --top-module rotator_top

clean:
	rm -rf obj_dir $(LOG)
